//--- all.f
verilog/params_pkg.sv
verilog/alu.sv
verilog/operand_fetch.sv
verilog/alu_stage.sv
verilog/mem_stage.sv
verilog/exec_core.sv
sim/exec_checker.sv
sim/tb_exec_core.sv

//--- sim/tb_exec_core.sv
`timescale 1ns/100ps

module tb_exec_core import params_pkg::*; ();

  localparam int NUM_RANDOM   = 2000;
  localparam int ACCEPT_LIMIT = 64;
  localparam int DRAIN_LIMIT  = 32;

  logic        clk;
  logic        rst;
  issue_t      issue;
  logic        mem_stall;
  logic        ready;
  retire_t     alu_retire;
  retire_t     load_retire;
  redirect_t   redirect;
  int          value_errs;
  int          other_errs;
  int          pending;
  int          timeouts  = 0;
  int          avoid_reg = -1;  // rd of the last accepted load.
  logic [31:0] rng       = 32'ha308_e803;
  logic [31:0] pc        = 32'h0000_1000;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng = xorshift(rng);
    r   = rng;
  endtask

  function automatic logic [4:0] pick_reg(input logic [4:0] r, input int avoid);
    return (int'(r) == avoid) ? r + 5'd1 : r;
  endfunction

  task automatic make_instr(output logic [31:0] w);
    logic [31:0] r;
    logic [31:0] s;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [11:0] maddr;
    logic [12:0] boff;
    logic [20:0] joff;
    next_rand(r);
    next_rand(s);
    rd    = pick_reg(s[4:0], avoid_reg);
    rs1   = pick_reg(s[9:5], avoid_reg);
    rs2   = pick_reg(s[14:10], avoid_reg);
    f3    = (r[6:4] == 3'd3) ? 3'd0 : r[6:4];  // no sltu.
    imm   = (f3[1:0] == 2'b01) ? {7'd0, s[24:20]} : s[31:20];
    // word index spread over the memory, byte lane only for byte access.
    maddr = {2'b00, r[9:8], 3'b000, r[12:10], r[15] ? 2'b00 : r[14:13]};
    boff  = {s[27:16], 1'b0};
    joff  = {s[31:12], 1'b0};
    avoid_reg = -1;
    case (r[3:0]) inside
      [4'd0:4'd4]: w = {(f3 == 3'd0 && r[7]) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, R};
      [4'd5:4'd8]: w = {imm, rs1, f3, rd, IMMEDIATE};
      [4'd9:4'd10]: begin
        w = {maddr, 5'd0, r[15] ? 3'b010 : 3'b000, rd, LOAD};
        avoid_reg = int'(rd);
      end
      [4'd11:4'd12]: w = {maddr[11:5], rs2, 5'd0, r[15] ? 3'b010 : 3'b000, maddr[4:0], STORE};
      [4'd13:4'd14]: begin
        w = {boff[12], boff[10:5], rs2, rs1, r[5], 1'b0, r[4], boff[4:1], boff[11], BRANCH};
      end
      default: w = {joff[20], joff[10:1], joff[11], joff[19:12], rd, JAL};
    endcase
  endtask

  // holds one instruction on the bus until the core takes it.
  task automatic issue_one(input logic [31:0] w);
    logic [31:0] r;
    logic        accepted;
    int          waits;
    accepted = 1'b0;
    waits    = 0;
    while (!accepted && timeouts == 0) begin
      next_rand(r);
      issue.instr = w;
      issue.pc    = pc;
      issue.valid = (r[2:0] != 3'd0);
      mem_stall   = (r[5:4] == 2'd0);
      @(posedge clk);
      accepted = issue.valid && ready;
      #0.5;
      waits++;
      if (!accepted && waits >= ACCEPT_LIMIT) begin
        timeouts++;
        $display("instruction at pc 0x%08h not accepted within %0d cycles", pc, waits);
      end
    end
    if (accepted)
      pc = pc + 32'd4;
  endtask

  task automatic idle_cycle();
    issue.valid = 1'b0;
    mem_stall   = 1'b0;
    @(posedge clk);
    #0.5;
  endtask

  initial begin
    logic [31:0] w;
    logic [31:0] r;
    int          waits;
    rst       = 1'b0;
    issue     = '0;
    mem_stall = 1'b0;
    repeat (3) @(posedge clk);
    #0.5;
    rst = 1'b1;
    idle_cycle();
    for (int i = 1; i < 32 && timeouts == 0; i++) begin
      next_rand(r);
      issue_one({r[11:0], 5'd0, 3'b000, 5'(i), IMMEDIATE});  // addi xi, x0, imm.
    end
    for (int n = 0; n < NUM_RANDOM && timeouts == 0; n++) begin
      make_instr(w);
      issue_one(w);
    end
    waits = 0;
    while (timeouts == 0 && pending != 0) begin
      idle_cycle();
      waits++;
      if (pending != 0 && waits >= DRAIN_LIMIT) begin
        timeouts++;
        $display("%0d loads still outstanding after %0d idle cycles", pending, waits);
      end
    end
    if (timeouts == 0)
      repeat (4) idle_cycle();
    $display("errors: value %0d, other %0d, timeout %0d", value_errs, other_errs, timeouts);
    if (value_errs == 0 && other_errs == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  exec_core #(
    .DATA_WIDTH      (DATA_WIDTH),
    .ADDR_WIDTH      (ADDR_WIDTH),
    .REGISTER_WIDTH  (REGISTER_WIDTH),
    .DMEM_ADDR_WIDTH (DMEM_ADDR_WIDTH)
  ) dut (
    .clk_i         (clk),
    .rst_i         (rst),
    .issue_i       (issue),
    .mem_stall_i   (mem_stall),
    .ready_o       (ready),
    .alu_retire_o  (alu_retire),
    .load_retire_o (load_retire),
    .redirect_o    (redirect)
  );

  exec_checker exec_checker (
    .clk_i         (clk),
    .rst_i         (rst),
    .issue_i       (issue),
    .mem_stall_i   (mem_stall),
    .ready_i       (ready),
    .alu_retire_i  (alu_retire),
    .load_retire_i (load_retire),
    .redirect_i    (redirect),
    .value_errs_o  (value_errs),
    .other_errs_o  (other_errs),
    .pending_o     (pending)
  );

endmodule : tb_exec_core

//--- sim/exec_checker.sv
`timescale 1ns/100ps

module exec_checker import params_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  issue_t    issue_i,
  input  logic      mem_stall_i,
  input  logic      ready_i,
  input  retire_t   alu_retire_i,
  input  retire_t   load_retire_i,
  input  redirect_t redirect_i,
  output int        value_errs_o,
  output int        other_errs_o,
  output int        pending_o
);

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] cycle;
    logic [31:0] stalls;
  } load_exp_t;

  logic [31:0] regs [32];
  logic [31:0] dmem [256];
  load_exp_t   exp_q [$];
  int          cycle_cnt   = 0;
  int          stall_cnt   = 0;
  logic        prev_stall  = 1'b0;
  logic        after_reset = 1'b0;

  initial begin
    value_errs_o = 0;
    other_errs_o = 0;
    pending_o    = 0;
    foreach (regs[i]) regs[i] = '0;
    foreach (dmem[i]) dmem[i] = '0;  // the data memory clears on reset.
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      value_errs_o++;
      $display("ERROR %s got 0x%08h exp 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic complain(input string msg);
    other_errs_o++;
    $display("%s at %0t", msg, $time);
  endtask

  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic sub,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b100:  return a ^ b;
      3'b101:  return a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic model_issue();
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] target;
    logic [7:0]  byte_v;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic        wb;
    logic        taken;
    w      = issue_i.instr;
    rd     = w[11:7];
    f3     = w[14:12];
    a      = regs[w[19:15]];
    b      = regs[w[24:20]];
    wb     = 1'b0;
    taken  = 1'b0;
    res    = '0;
    target = '0;
    case (w[6:0])
      R: begin
        wb  = 1'b1;
        res = ref_alu(f3, w[30], a, b);
      end
      IMMEDIATE: begin
        wb  = 1'b1;
        res = ref_alu(f3, 1'b0, a, {{20{w[31]}}, w[31:20]});
      end
      LOAD: begin
        addr   = a + {{20{w[31]}}, w[31:20]};
        word   = dmem[addr[9:2]];
        byte_v = word[addr[1:0]*8 +: 8];
        if (rd != 5'd0) begin
          regs[rd] = (f3 == 3'b010) ? word : {{24{byte_v[7]}}, byte_v};
          exp_q.push_back({rd, regs[rd], 32'(cycle_cnt), 32'(stall_cnt)});
        end
      end
      STORE: begin
        addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
        if (f3 == 3'b010)
          dmem[addr[9:2]] = b;
        else
          dmem[addr[9:2]][addr[1:0]*8 +: 8] = b[7:0];
      end
      BRANCH: begin
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          default: taken = ($signed(a) >= $signed(b));
        endcase
        target = issue_i.pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      end
      JAL: begin
        wb     = 1'b1;
        taken  = 1'b1;
        res    = issue_i.pc + 32'd4;
        target = issue_i.pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      default: complain("issued word has an unsupported opcode");
    endcase
    check_value("alu_retire_o.valid", 32'(alu_retire_i.valid), 32'(wb));
    if (wb) begin
      check_value("alu_retire_o.rd", 32'(alu_retire_i.rd), 32'(rd));
      check_value("alu_retire_o.data", alu_retire_i.data, res);
      if (rd != 5'd0)
        regs[rd] = res;
    end
    check_value("redirect_o.taken", 32'(redirect_i.taken), 32'(taken));
    if (taken)
      check_value("redirect_o.target", redirect_i.target, target);
  endtask

  task automatic check_load_retire();
    load_exp_t e;
    if (load_retire_i.valid) begin
      if (prev_stall)
        complain("load retire appeared for a request held by a stall");
      if (exp_q.size() == 0) begin
        complain("load retire appeared with no load outstanding");
      end else begin
        e = exp_q.pop_front();
        check_value("load_retire_o.rd", 32'(load_retire_i.rd), 32'(e.rd));
        check_value("load_retire_o.data", load_retire_i.data, e.data);
        if (32'(stall_cnt) == e.stalls)  // no stall since issue.
          check_value("load_retire_o latency", 32'(cycle_cnt) - e.cycle, 32'd2);
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (!rst_i) begin
      after_reset = 1'b1;
    end else begin
      cycle_cnt++;
      if (after_reset && (alu_retire_i.valid || load_retire_i.valid || redirect_i.taken))
        complain("retire or redirect active in the first cycle after reset");
      after_reset = 1'b0;
      if (ready_i !== !mem_stall_i)
        complain("ready_o does not follow mem_stall_i");
      check_load_retire();
      if (issue_i.valid && !mem_stall_i) begin
        model_issue();
      end else begin
        check_value("alu_retire_o.valid", 32'(alu_retire_i.valid), 32'd0);
        check_value("redirect_o.taken", 32'(redirect_i.taken), 32'd0);
      end
      if (mem_stall_i)
        stall_cnt++;
      prev_stall = mem_stall_i;
    end
    pending_o = exp_q.size();
  end

endmodule : exec_checker

//--- verilog/exec_core.sv
`timescale 1ns/100ps

module exec_core import params_pkg::*; #(
  parameter int DATA_WIDTH      = params_pkg::DATA_WIDTH,
  parameter int ADDR_WIDTH      = params_pkg::ADDR_WIDTH,
  parameter int REGISTER_WIDTH  = params_pkg::REGISTER_WIDTH,
  parameter int DMEM_ADDR_WIDTH = params_pkg::DMEM_ADDR_WIDTH
)(
  input  logic      clk_i,
  input  logic      rst_i,
  input  issue_t    issue_i,
  input  logic      mem_stall_i,
  output logic      ready_o,
  output retire_t   alu_retire_o,
  output retire_t   load_retire_o,
  output redirect_t redirect_o
);

  operands_t operands;
  mem_req_t  mem_req;

  assign ready_o = !mem_stall_i;

  operand_fetch #(
    .DATA_WIDTH     (DATA_WIDTH),
    .REGISTER_WIDTH (REGISTER_WIDTH)
  ) u_operand_fetch (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .issue_i    (issue_i),
    .stall_i    (mem_stall_i),
    .alu_wr_i   (alu_retire_o),
    .load_wr_i  (load_retire_o),
    .operands_o (operands)
  );

  alu_stage #(
    .DATA_WIDTH     (DATA_WIDTH),
    .REGISTER_WIDTH (REGISTER_WIDTH),
    .ADDR_WIDTH     (ADDR_WIDTH)
  ) u_alu_stage (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .operands_i   (operands),
    .mem_stall_i  (mem_stall_i),
    .alu_retire_o (alu_retire_o),
    .redirect_o   (redirect_o),
    .mem_req_o    (mem_req)
  );

  mem_stage #(
    .DATA_WIDTH      (DATA_WIDTH),
    .DMEM_ADDR_WIDTH (DMEM_ADDR_WIDTH)
  ) u_mem_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .mem_req_i     (mem_req),
    .mem_stall_i   (mem_stall_i),
    .load_retire_o (load_retire_o)
  );

endmodule : exec_core

//--- verilog/mem_stage.sv
`timescale 1ns/100ps

module mem_stage import params_pkg::*; #(
  parameter int DATA_WIDTH      = params_pkg::DATA_WIDTH,
  parameter int DMEM_ADDR_WIDTH = params_pkg::DMEM_ADDR_WIDTH
)(
  input  logic     clk_i,
  input  logic     rst_i,
  input  mem_req_t mem_req_i,
  input  logic     mem_stall_i,
  output retire_t  load_retire_o
);

  localparam int LANE_BITS = $clog2(DATA_WIDTH / 8);
  localparam int DEPTH     = 2 ** DMEM_ADDR_WIDTH;

  logic [DATA_WIDTH-1:0]      mem [DEPTH];
  logic [DMEM_ADDR_WIDTH-1:0] word_idx;
  logic [LANE_BITS-1:0]       lane;
  logic [DATA_WIDTH-1:0]      rd_word;
  logic [7:0]                 rd_byte;
  logic [DATA_WIDTH-1:0]      load_data;
  logic                       access;

  assign word_idx = mem_req_i.addr[LANE_BITS +: DMEM_ADDR_WIDTH];
  assign lane     = mem_req_i.addr[LANE_BITS-1:0];
  assign access   = mem_req_i.valid && !mem_stall_i;  // a held request waits.

  assign rd_word   = mem[word_idx];
  assign rd_byte   = rd_word[lane*8 +: 8];
  assign load_data = (mem_req_i.size == WORD) ? rd_word
                                              : {{(DATA_WIDTH-8){rd_byte[7]}}, rd_byte};

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      load_retire_o.valid <= 1'b0;
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else begin
      load_retire_o.valid <= access && mem_req_i.is_load && mem_req_i.reg_wr_en;
      load_retire_o.rd    <= mem_req_i.rd;
      load_retire_o.data  <= load_data;
      if (access && mem_req_i.is_store) begin
        if (mem_req_i.size == WORD)
          mem[word_idx] <= mem_req_i.wdata;
        else
          mem[word_idx][lane*8 +: 8] <= mem_req_i.wdata[7:0];
      end
    end
  end

  // word addresses come from the execute stage adder.
  assert property (@(posedge clk_i) disable iff (!rst_i)
    access && mem_req_i.size == WORD |-> mem_req_i.addr[LANE_BITS-1:0] == '0)
    else $error("misaligned word access");

endmodule : mem_stage

//--- verilog/alu_stage.sv
`timescale 1ns/100ps

module alu_stage import params_pkg::*; #(
  parameter int DATA_WIDTH     = params_pkg::DATA_WIDTH,
  parameter int REGISTER_WIDTH = params_pkg::REGISTER_WIDTH,
  parameter int ADDR_WIDTH     = params_pkg::ADDR_WIDTH
)(
  input  logic      clk_i,
  input  logic      rst_i,
  input  operands_t operands_i,
  input  logic      mem_stall_i,
  output retire_t   alu_retire_o,
  output redirect_t redirect_o,
  output mem_req_t  mem_req_o
);

  instruction_t              instr;
  logic [REGISTER_WIDTH-1:0] rd;
  logic [ADDR_WIDTH-1:0]     target;
  logic [DATA_WIDTH-1:0]     alu_a;
  logic [DATA_WIDTH-1:0]     alu_b;
  logic [DATA_WIDTH-1:0]     alu_result;
  logic                      is_zero;
  logic                      is_less;
  logic                      valid;
  logic                      wb_alu;
  logic                      taken;
  mem_req_t                  mem_req_d;

  assign instr  = operands_i.instr;
  assign valid  = operands_i.valid;
  assign rd     = instr.r_fmt.rd;
  assign target = operands_i.pc + ADDR_WIDTH'(operands_i.offset);

  always_comb begin
    alu_a  = operands_i.data_a;
    alu_b  = operands_i.data_b;
    wb_alu = 1'b0;
    taken  = 1'b0;

    mem_req_d.valid     = 1'b0;
    mem_req_d.is_load   = 1'b0;
    mem_req_d.is_store  = 1'b0;
    mem_req_d.reg_wr_en = 1'b0;
    mem_req_d.size      = (instr.r_fmt.funct3[1:0] == 2'b10) ? WORD : BYTE;
    mem_req_d.addr      = alu_result;
    mem_req_d.wdata     = operands_i.data_b;  // rs2 value.
    mem_req_d.rd        = rd;

    case (instr.r_fmt.opcode)
      R: begin
        wb_alu = valid;
      end
      IMMEDIATE: begin
        wb_alu = valid;
        alu_b  = operands_i.offset;
      end
      LOAD: begin
        alu_b               = operands_i.offset;
        mem_req_d.valid     = valid;
        mem_req_d.is_load   = 1'b1;
        mem_req_d.reg_wr_en = (rd != '0);  // x0 loads access memory but write nothing.
      end
      STORE: begin
        alu_b              = operands_i.offset;
        mem_req_d.valid    = valid;
        mem_req_d.is_store = 1'b1;
      end
      BRANCH: begin
        case (instr.r_fmt.funct3)
          3'b000:  taken = valid && is_zero;   // beq.
          3'b001:  taken = valid && !is_zero;  // bne.
          3'b100:  taken = valid && is_less;   // blt.
          3'b101:  taken = valid && !is_less;  // bge.
          default: taken = 1'b0;
        endcase
      end
      JAL: begin
        wb_alu = valid;
        taken  = valid;
        alu_a  = DATA_WIDTH'(operands_i.pc);
        alu_b  = DATA_WIDTH'(4);  // link address.
      end
      default: ;
    endcase
  end

  assign alu_retire_o.valid = wb_alu;
  assign alu_retire_o.rd    = rd;
  assign alu_retire_o.data  = alu_result;

  assign redirect_o.taken  = taken;
  assign redirect_o.target = target;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      mem_req_o.valid     <= 1'b0;
      mem_req_o.is_load   <= 1'b0;
      mem_req_o.is_store  <= 1'b0;
      mem_req_o.reg_wr_en <= 1'b0;
    end else if (!mem_stall_i) begin
      mem_req_o <= mem_req_d;
    end
  end

  alu #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_alu (
    .opcode_i  (instr.r_fmt.opcode),
    .funct3_i  (instr.r_fmt.funct3),
    .funct7_i  (instr.r_fmt.funct7),
    .a_i       (alu_a),
    .b_i       (alu_b),
    .is_zero_o (is_zero),
    .is_less_o (is_less),
    .result_o  (alu_result)
  );

  assert property (@(posedge clk_i) disable iff (!rst_i)
    mem_req_o.valid |-> !(mem_req_o.is_load && mem_req_o.is_store))
    else $error("memory request is both load and store");

endmodule : alu_stage

//--- verilog/operand_fetch.sv
`timescale 1ns/100ps

module operand_fetch import params_pkg::*; #(
  parameter int DATA_WIDTH     = params_pkg::DATA_WIDTH,
  parameter int REGISTER_WIDTH = params_pkg::REGISTER_WIDTH
)(
  input  logic      clk_i,
  input  logic      rst_i,
  input  issue_t    issue_i,
  input  logic      stall_i,
  input  retire_t   alu_wr_i,
  input  retire_t   load_wr_i,
  output operands_t operands_o
);

  localparam int NUM_REGS = 2 ** REGISTER_WIDTH;

  logic [DATA_WIDTH-1:0]     regs [NUM_REGS];
  logic [REGISTER_WIDTH-1:0] rs1;
  logic [REGISTER_WIDTH-1:0] rs2;
  logic [DATA_WIDTH-1:0]     offset;
  instruction_t              instr;

  assign instr = issue_i.instr;
  assign rs1   = instr.r_fmt.rs1;
  assign rs2   = instr.r_fmt.rs2;

  // the load write lands this cycle, so a reader of the same register sees it now.
  function automatic logic [DATA_WIDTH-1:0] read_reg(input logic [REGISTER_WIDTH-1:0] idx);
    logic [DATA_WIDTH-1:0] val;
    val = regs[idx];
    if (load_wr_i.valid && load_wr_i.rd == idx)
      val = load_wr_i.data;
    if (idx == '0)
      val = '0;
    return val;
  endfunction

  always_ff @(posedge clk_i) begin
    if (load_wr_i.valid && load_wr_i.rd != '0)
      regs[load_wr_i.rd] <= load_wr_i.data;
    if (alu_wr_i.valid && alu_wr_i.rd != '0)
      regs[alu_wr_i.rd] <= alu_wr_i.data;  // younger write, overrides the load.
  end

  always_comb begin
    case (instr.r_fmt.opcode)
      STORE: begin
        offset = {{(DATA_WIDTH-12){instr.s_fmt.imm_hi[6]}},
                  instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
      end
      BRANCH: begin
        offset = {{(DATA_WIDTH-13){instr.b_fmt.imm_12}}, instr.b_fmt.imm_12,
                  instr.b_fmt.imm_11, instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
      end
      JAL: begin
        // J immediate rebuilt from the I view fields.
        offset = {{(DATA_WIDTH-21){instr.i_fmt.imm[11]}}, instr.i_fmt.imm[11],
                  instr.i_fmt.rs1, instr.i_fmt.funct3, instr.i_fmt.imm[0],
                  instr.i_fmt.imm[10:1], 1'b0};
      end
      default: begin
        offset = {{(DATA_WIDTH-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
      end
    endcase
  end

  always_comb begin
    operands_o.data_a = read_reg(rs1);
    operands_o.data_b = read_reg(rs2);
    operands_o.offset = offset;
    operands_o.pc     = issue_i.pc;
    operands_o.instr  = instr;
    operands_o.valid  = issue_i.valid && !stall_i;
  end

  // loads aimed at x0 never request a write, so x0 is never contended.
  assert property (@(posedge clk_i) disable iff (!rst_i)
    !(alu_wr_i.valid && load_wr_i.valid && alu_wr_i.rd == '0 && load_wr_i.rd == '0))
    else $error("both write ports target register 0");

endmodule : operand_fetch

//--- verilog/alu.sv
`timescale 1ns/100ps

module alu import params_pkg::*; #(
  parameter int DATA_WIDTH = params_pkg::DATA_WIDTH
)(
  input  opcode_t               opcode_i,
  input  logic [2:0]            funct3_i,
  input  logic [6:0]            funct7_i,
  input  logic [DATA_WIDTH-1:0] a_i,
  input  logic [DATA_WIDTH-1:0] b_i,
  output logic                  is_zero_o,
  output logic                  is_less_o,
  output logic [DATA_WIDTH-1:0] result_o
);

  localparam int SHAMT_WIDTH = $clog2(DATA_WIDTH);

  logic [DATA_WIDTH-1:0]  sum;
  logic [DATA_WIDTH-1:0]  diff;
  logic [SHAMT_WIDTH-1:0] shamt;
  logic                   lt;
  logic                   use_sub;

  assign sum   = a_i + b_i;
  assign diff  = a_i - b_i;
  assign shamt = b_i[SHAMT_WIDTH-1:0];

  // signed compare from the difference, sign bits decide on mixed signs.
  assign lt = (a_i[DATA_WIDTH-1] != b_i[DATA_WIDTH-1]) ? a_i[DATA_WIDTH-1]
                                                       : diff[DATA_WIDTH-1];

  assign use_sub = (opcode_i == R) && funct7_i[5];  // immediate ops have no SUB.

  always_comb begin
    result_o = sum;
    case (opcode_i)
      R, IMMEDIATE: begin
        case (funct3_i)
          3'b000:  result_o = use_sub ? diff : sum;
          3'b001:  result_o = a_i << shamt;
          3'b010:  result_o = {{(DATA_WIDTH-1){1'b0}}, lt};
          3'b100:  result_o = a_i ^ b_i;
          3'b101:  result_o = a_i >> shamt;
          3'b110:  result_o = a_i | b_i;
          3'b111:  result_o = a_i & b_i;
          default: result_o = sum;
        endcase
      end
      BRANCH:  result_o = diff;
      default: result_o = sum;   // load, store and jal addresses.
    endcase
  end

  assign is_zero_o = (diff == '0);
  assign is_less_o = lt;

endmodule : alu

//--- verilog/params_pkg.sv
package params_pkg;

  parameter int DATA_WIDTH      = 32;
  parameter int ADDR_WIDTH      = 32;
  parameter int REGISTER_WIDTH  = 5;
  parameter int DMEM_ADDR_WIDTH = 8;   // word address bits of the data memory.

  typedef enum logic [6:0] {
    R         = 7'b0110011,
    IMMEDIATE = 7'b0010011,
    LOAD      = 7'b0000011,
    STORE     = 7'b0100011,
    BRANCH    = 7'b1100011,
    JAL       = 7'b1101111
  } opcode_t;

  typedef enum logic {
    BYTE = 1'b0,
    WORD = 1'b1
  } access_size_t;

  // one instruction word, four ways to look at it.
  typedef union packed {
    struct packed {
      logic [6:0]                funct7;
      logic [REGISTER_WIDTH-1:0] rs2;
      logic [REGISTER_WIDTH-1:0] rs1;
      logic [2:0]                funct3;
      logic [REGISTER_WIDTH-1:0] rd;
      opcode_t                   opcode;
    } r_fmt;
    struct packed {
      logic [11:0]               imm;
      logic [REGISTER_WIDTH-1:0] rs1;
      logic [2:0]                funct3;
      logic [REGISTER_WIDTH-1:0] rd;
      opcode_t                   opcode;
    } i_fmt;
    struct packed {
      logic [6:0]                imm_hi;
      logic [REGISTER_WIDTH-1:0] rs2;
      logic [REGISTER_WIDTH-1:0] rs1;
      logic [2:0]                funct3;
      logic [4:0]                imm_lo;
      opcode_t                   opcode;
    } s_fmt;
    struct packed {
      logic                      imm_12;
      logic [5:0]                imm_10_5;
      logic [REGISTER_WIDTH-1:0] rs2;
      logic [REGISTER_WIDTH-1:0] rs1;
      logic [2:0]                funct3;
      logic [3:0]                imm_4_1;
      logic                      imm_11;
      opcode_t                   opcode;
    } b_fmt;
  } instruction_t;

  typedef struct packed {
    instruction_t          instr;
    logic [ADDR_WIDTH-1:0] pc;
    logic                  valid;
  } issue_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data_a;
    logic [DATA_WIDTH-1:0] data_b;
    logic [DATA_WIDTH-1:0] offset;   // sign-extended immediate.
    logic [ADDR_WIDTH-1:0] pc;
    instruction_t          instr;
    logic                  valid;
  } operands_t;

  typedef struct packed {
    logic                      valid;
    logic                      is_load;
    logic                      is_store;
    logic                      reg_wr_en;
    access_size_t              size;
    logic [DATA_WIDTH-1:0]     addr;
    logic [DATA_WIDTH-1:0]     wdata;
    logic [REGISTER_WIDTH-1:0] rd;
  } mem_req_t;

  typedef struct packed {
    logic                      valid;
    logic [REGISTER_WIDTH-1:0] rd;
    logic [DATA_WIDTH-1:0]     data;
  } retire_t;

  typedef struct packed {
    logic                  taken;
    logic [ADDR_WIDTH-1:0] target;
  } redirect_t;

endpackage : params_pkg
